// File: logic/fpu_dma_pkg.sv
`default_nettype none

package fpu_dma_pkg;

	localparam int line_bytes = 64;
	localparam int word_bytes = 8;
	localparam int words_per_line = 8;
	localparam int tile_rows = 4;
	localparam int row_lines = 2;
	localparam int row_bytes = row_lines * line_bytes;
	localparam int buf_bytes = tile_rows * row_bytes;
	localparam int buf_addr_w = $clog2(buf_bytes);
	localparam int addr_w = 32;

	localparam int byte_idx_w = $clog2(line_bytes);
	localparam int word_idx_w = $clog2(words_per_line);
	localparam int line_idx_w = $clog2(row_lines);
	localparam int row_idx_w = $clog2(tile_rows);

	// byte 0 and word 0 both sit at the top
	typedef union packed {
		logic [0:line_bytes-1][7:0] bytes;
		logic [0:words_per_line-1][word_bytes*8-1:0] words;
	} cache_line_u;

	typedef struct packed {
		logic read;
		logic write;
		logic [addr_w-1:0] base_addr;
		logic [addr_w-1:0] stride; // bytes between rows
		logic [1:0] lines; // lines per row
		logic [2:0] rows;
	} dma_cmd_t;

	typedef struct packed {
		logic request;
		logic rd_wr; // 1 = write
		logic [addr_w-1:0] address;
		logic [7:0] request_size; // in lines
		logic fpu_ready;
		cache_line_u write_data;
	} dram_req_t;

	typedef struct packed {
		logic dram_ready;
		logic request_done;
		cache_line_u read_data;
	} dram_rsp_t;

	typedef enum logic [3:0] {
		IDLE,
		START_READ_REQUEST,
		WAIT_DRAM_READY_READ,
		SAVE_DATA,
		SAVE_END,
		FPU_READY_READ,
		START_WRITE_REQUEST,
		LOAD_WRITE_DATA,
		LAST_SHIFT,
		WAIT_DRAM_READY_WRITE,
		SEND_WRITE_LINE,
		WAIT_DONE,
		UPDATE_ADDRESS
	} xfer_state_e;

endpackage

`default_nettype wire

// File: logic/fpu_dma_fsm.sv
`default_nettype none

module fpu_dma_fsm import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dma_cmd_t cmd,
	input wire dram_rsp_t rsp,
	input wire last_byte,
	input wire last_word,
	input wire last_line,
	input wire last_row,
	output xfer_state_e state,
	output logic busy,
	output logic req_pulse,
	output logic rd_wr,
	output logic fpu_ready,
	output logic shift_en,
	output logic load,
	output logic emit_en
);

	xfer_state_e next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next;
		end
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: begin
				if (start && cmd.write) begin
					next = START_WRITE_REQUEST;
				end else if (start && cmd.read) begin
					next = START_READ_REQUEST;
				end
			end

			START_READ_REQUEST: next = WAIT_DRAM_READY_READ;

			WAIT_DRAM_READY_READ: begin
				if (rsp.dram_ready) begin
					next = SAVE_DATA; // line captured this cycle
				end
			end

			SAVE_DATA: begin
				if (last_word) begin
					next = SAVE_END;
				end
			end

			SAVE_END: next = FPU_READY_READ; // last word lands here

			FPU_READY_READ: next = last_line ? WAIT_DONE : WAIT_DRAM_READY_READ;

			START_WRITE_REQUEST: next = LOAD_WRITE_DATA;

			LOAD_WRITE_DATA: begin
				if (last_byte) begin
					next = LAST_SHIFT;
				end
			end

			LAST_SHIFT: next = WAIT_DRAM_READY_WRITE;

			WAIT_DRAM_READY_WRITE: begin
				if (rsp.dram_ready) begin
					next = SEND_WRITE_LINE;
				end
			end

			SEND_WRITE_LINE: next = last_line ? WAIT_DONE : LOAD_WRITE_DATA;

			WAIT_DONE: begin
				if (rsp.request_done) begin
					next = last_row ? IDLE : UPDATE_ADDRESS;
				end
			end

			UPDATE_ADDRESS: next = rd_wr ? START_WRITE_REQUEST : START_READ_REQUEST;

			default: next = IDLE;
		endcase
	end

	// sample the line on the very cycle dram_ready is seen
	assign load = (state == WAIT_DRAM_READY_READ) && rsp.dram_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			req_pulse <= 1'b0;
			rd_wr <= 1'b0;
			fpu_ready <= 1'b0;
			shift_en <= 1'b0;
			emit_en <= 1'b0;
		end else begin
			busy <= (next != IDLE);
			req_pulse <= (next == START_READ_REQUEST) || (next == START_WRITE_REQUEST);
			fpu_ready <= (next == SEND_WRITE_LINE) || (next == FPU_READY_READ);
			// first load cycle only addresses, shifting starts one later
			shift_en <= (next == LAST_SHIFT) ||
				((next == LOAD_WRITE_DATA) && (state == LOAD_WRITE_DATA));
			emit_en <= (next == SAVE_DATA);
			if ((state == IDLE) && (next != IDLE)) begin
				rd_wr <= (next == START_WRITE_REQUEST); // held for whole command
			end
		end
	end

	// dram must keep ready up until the line handshake
	fpu_ready_needs_dram_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		fpu_ready |-> rsp.dram_ready
	) else $error("fpu_ready asserted while dram_ready low");

endmodule

`default_nettype wire

// File: logic/fpu_dma_counters.sv
`default_nettype none

module fpu_dma_counters import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dma_cmd_t cmd,
	input wire xfer_state_e state,
	output logic [addr_w-1:0] address,
	output logic [7:0] request_size,
	output logic [buf_addr_w-1:0] buf_rd_addr,
	output logic [buf_addr_w-1:0] buf_wr_addr,
	output logic last_byte,
	output logic last_word,
	output logic last_line,
	output logic last_row
);

	dma_cmd_t cmd_q;
	logic [byte_idx_w-1:0] byte_cnt;
	logic [word_idx_w-1:0] word_cnt;
	logic [line_idx_w-1:0] line_cnt;
	logic [2:0] row_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q <= '0;
			address <= '0;
			byte_cnt <= '0;
			word_cnt <= '0;
			line_cnt <= '0;
			row_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						cmd_q <= cmd;
						address <= cmd.base_addr;
						row_cnt <= '0;
						byte_cnt <= '0;
						word_cnt <= '0;
					end
				end
				START_READ_REQUEST, START_WRITE_REQUEST: line_cnt <= '0;
				LOAD_WRITE_DATA: byte_cnt <= byte_cnt + 1'b1; // wraps per line
				SAVE_DATA: word_cnt <= word_cnt + 1'b1;
				FPU_READY_READ, SEND_WRITE_LINE: line_cnt <= line_cnt + 1'b1;
				UPDATE_ADDRESS: begin
					address <= address + cmd_q.stride;
					row_cnt <= row_cnt + 3'd1;
				end
				default: ;
			endcase
		end
	end

	// word address follows the unpacker's registered word by one cycle
	always_ff @(posedge clk) begin
		if (state == SAVE_DATA) begin
			buf_wr_addr <= {row_cnt[row_idx_w-1:0], line_cnt, word_cnt,
				{$clog2(word_bytes){1'b0}}};
		end
	end

	assign buf_rd_addr = {row_cnt[row_idx_w-1:0], line_cnt, byte_cnt};
	assign request_size = 8'(cmd_q.lines);

	assign last_byte = (byte_cnt == byte_idx_w'(line_bytes - 1));
	assign last_word = (word_cnt == word_idx_w'(words_per_line - 1));
	assign last_line = (2'(line_cnt) == cmd_q.lines - 2'd1);
	assign last_row = (row_cnt == cmd_q.rows - 3'd1);

	row_count_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state != IDLE) |-> (row_cnt < cmd_q.rows)
	) else $error("row counter ran past the commanded row count");

endmodule

`default_nettype wire

// File: logic/line_packer.sv
`default_nettype none

module line_packer import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire shift_en,
	input wire clear,
	input wire [7:0] rd_byte,
	output cache_line_u line
);

	// oldest byte drifts up to byte 0 after a full line of shifts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line <= '0;
		end else if (clear) begin
			line <= '0; // line handed to dram
		end else if (shift_en) begin
			line.bytes <= {line.bytes[1:line_bytes-1], rd_byte};
		end
	end

endmodule

`default_nettype wire

// File: logic/line_unpacker.sv
`default_nettype none

module line_unpacker import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire emit_en,
	input wire cache_line_u read_data,
	output logic [word_bytes*8-1:0] word_data,
	output logic word_we
);

	cache_line_u line_q;
	logic [word_idx_w-1:0] idx;

	always_ff @(posedge clk) begin
		if (load) begin
			line_q <= read_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
			word_we <= 1'b0;
		end else begin
			word_we <= emit_en; // one pulse per emitted word
			if (load) begin
				idx <= '0;
			end else if (emit_en) begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit_en) begin
			word_data <= line_q.words[idx];
		end
	end

endmodule

`default_nettype wire

// File: logic/tile_buffer.sv
`default_nettype none

module tile_buffer import fpu_dma_pkg::*; (
	input wire clk,
	input wire busy,
	input wire [buf_addr_w-1:0] rd_addr,
	input wire [buf_addr_w-1:0] wr_addr,
	input wire [word_bytes*8-1:0] word_data,
	input wire word_we,
	input wire [buf_addr_w-1:0] fpu_addr,
	input wire [7:0] fpu_wdata,
	input wire fpu_we,
	output logic [7:0] rd_byte,
	output logic [7:0] fpu_rdata
);

	logic [7:0] mem [buf_bytes];

	always_ff @(posedge clk) begin
		if (word_we) begin
			for (int i = 0; i < word_bytes; i++) begin
				// word byte 0 is the top byte
				mem[wr_addr + buf_addr_w'(i)] <= word_data[(word_bytes-1-i)*8 +: 8];
			end
		end else if (fpu_we && !busy) begin
			mem[fpu_addr] <= fpu_wdata;
		end
		rd_byte <= mem[rd_addr];
		if (!busy) begin
			fpu_rdata <= mem[fpu_addr]; // fpu side only while idle
		end
	end

	fpu_write_only_when_idle: assert property (
		@(posedge clk) fpu_we |-> !busy
	) else $error("fpu byte write attempted during a transfer");

endmodule

`default_nettype wire

// File: logic/fpu_dma_top.sv
`default_nettype none

module fpu_dma_top import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire dma_cmd_t cmd,
	output wire busy,
	output wire dram_req_t req,
	input wire dram_rsp_t rsp,
	input wire [buf_addr_w-1:0] fpu_addr,
	input wire [7:0] fpu_wdata,
	input wire fpu_we,
	output wire [7:0] fpu_rdata
);

	xfer_state_e state;
	logic last_byte;
	logic last_word;
	logic last_line;
	logic last_row;
	logic shift_en;
	logic load;
	logic emit_en;
	logic [buf_addr_w-1:0] buf_rd_addr;
	logic [buf_addr_w-1:0] buf_wr_addr;
	logic [7:0] rd_byte;
	logic [word_bytes*8-1:0] word_data;
	logic word_we;

	fpu_dma_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.cmd(cmd),
		.rsp(rsp),
		.last_byte(last_byte),
		.last_word(last_word),
		.last_line(last_line),
		.last_row(last_row),
		.state(state),
		.busy(busy),
		.req_pulse(req.request),
		.rd_wr(req.rd_wr),
		.fpu_ready(req.fpu_ready),
		.shift_en(shift_en),
		.load(load),
		.emit_en(emit_en)
	);

	fpu_dma_counters u_counters (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.cmd(cmd),
		.state(state),
		.address(req.address),
		.request_size(req.request_size),
		.buf_rd_addr(buf_rd_addr),
		.buf_wr_addr(buf_wr_addr),
		.last_byte(last_byte),
		.last_word(last_word),
		.last_line(last_line),
		.last_row(last_row)
	);

	line_packer u_packer (
		.clk(clk),
		.rst_n(rst_n),
		.shift_en(shift_en),
		.clear(req.fpu_ready), // cleared once the line is taken
		.rd_byte(rd_byte),
		.line(req.write_data)
	);

	line_unpacker u_unpacker (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.emit_en(emit_en),
		.read_data(rsp.read_data),
		.word_data(word_data),
		.word_we(word_we)
	);

	tile_buffer u_buffer (
		.clk(clk),
		.busy(busy),
		.rd_addr(buf_rd_addr),
		.wr_addr(buf_wr_addr),
		.word_data(word_data),
		.word_we(word_we),
		.fpu_addr(fpu_addr),
		.fpu_wdata(fpu_wdata),
		.fpu_we(fpu_we),
		.rd_byte(rd_byte),
		.fpu_rdata(fpu_rdata)
	);

endmodule

`default_nettype wire

// File: sim/dram_model.sv
`default_nettype none

module dram_model import fpu_dma_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire dram_req_t req,
	output dram_rsp_t rsp
);

	logic [7:0] mem [4096]; // 4 KB, byte addressed
	logic [31:0] lfsr = 32'h38f2224f;
	logic [11:0] line_addr;
	logic [7:0] lines_left;
	logic [2:0] gap;
	logic active;

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[6:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0); // galois step
		end
		return val;
	endfunction

	initial begin
		for (int a = 0; a < 4096; a++) begin
			mem[a] = take_bits(8);
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp <= '0;
			active <= 1'b0;
			line_addr <= '0;
			lines_left <= '0;
			gap <= '0;
		end else begin
			rsp.request_done <= 1'b0;
			if (req.request) begin
				active <= 1'b1;
				line_addr <= req.address[11:0];
				lines_left <= req.request_size;
				gap <= 3'(take_bits(3));
			end else if (active && req.fpu_ready) begin
				if (req.rd_wr) begin
					for (int i = 0; i < line_bytes; i++) begin
						mem[line_addr + 12'(i)] <= req.write_data.bytes[i]; // byte 0 lowest
					end
				end
				rsp.dram_ready <= 1'b0;
				line_addr <= line_addr + 12'(line_bytes);
				lines_left <= lines_left - 8'd1;
				gap <= 3'(take_bits(3));
				active <= (lines_left != 8'd1);
				rsp.request_done <= (lines_left == 8'd1); // after the last line
			end else if (active && !rsp.dram_ready) begin
				if (gap != 3'd0) begin
					gap <= gap - 3'd1;
				end else begin
					rsp.dram_ready <= 1'b1; // held until the line handshake
					for (int i = 0; i < line_bytes; i++) begin
						rsp.read_data.bytes[i] <= mem[line_addr + 12'(i)];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_fpu_dma.sv
`default_nettype none

module tb_fpu_dma import fpu_dma_pkg::*; ();

	localparam int max_cycles = 20000; // far above three tiles plus buffer access

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic start = 1'b0;
	dma_cmd_t cmd = '0;
	logic [buf_addr_w-1:0] fpu_addr = '0;
	logic [7:0] fpu_wdata = '0;
	logic fpu_we = 1'b0;
	logic busy;
	dram_req_t req;
	dram_rsp_t rsp;
	logic [7:0] fpu_rdata;
	logic started = 1'b0;
	logic exp_write = 1'b0;
	logic [addr_w-1:0] exp_base = '0;
	logic [addr_w-1:0] exp_stride = '0;
	logic [2:0] row_idx = '0;
	logic [7:0] ready_count = '0;
	logic [31:0] lfsr = 32'h38f2224f;
	logic [7:0] tile [buf_bytes]; // expected buffer image
	int cycles = 0;

	fpu_dma_top dut (
		.clk(clk), .rst_n(rst_n), .start(start), .cmd(cmd), .busy(busy),
		.req(req), .rsp(rsp), .fpu_addr(fpu_addr), .fpu_wdata(fpu_wdata),
		.fpu_we(fpu_we), .fpu_rdata(fpu_rdata)
	);

	dram_model dram (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

	always #4 clk = ~clk;

	task automatic raise_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "%s", msg);
	endtask

	function automatic logic [7:0] next_random_byte();
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < 8; i++) begin
			val = {val[6:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return val;
	endfunction

	task automatic run_command(input logic is_write, input logic [addr_w-1:0] base,
		input logic [addr_w-1:0] stride, input logic poke_busy);
		@(posedge clk);
		cmd <= '{read: !is_write, write: is_write, base_addr: base, stride: stride,
			lines: 2'(row_lines), rows: 3'(tile_rows)};
		start <= 1'b1;
		started <= 1'b1;
		exp_write <= is_write;
		exp_base <= base;
		exp_stride <= stride;
		@(posedge clk);
		start <= 1'b0;
		if (poke_busy) begin
			repeat (3) @(posedge clk);
			cmd <= '{read: 1'b1, write: 1'b1, base_addr: 32'hf00, stride: 32'h10,
				lines: 2'd1, rows: 3'd1};
			start <= 1'b1; // engine is busy here
			@(posedge clk);
			start <= 1'b0;
		end
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		assert (row_idx == 3'(tile_rows)) else raise_error("wrong number of row requests");
	endtask

	task automatic preload_buffer();
		for (int a = 0; a < buf_bytes; a++) begin
			@(posedge clk);
			tile[a] = next_random_byte();
			fpu_addr <= buf_addr_w'(a);
			fpu_wdata <= tile[a];
			fpu_we <= 1'b1;
		end
		@(posedge clk);
		fpu_we <= 1'b0;
	endtask

	// buffer against the dram tile, which becomes the new expected image
	task automatic check_buffer(input logic [addr_w-1:0] base, input logic [addr_w-1:0] stride);
		for (int a = 0; a < buf_bytes; a++) begin
			@(posedge clk);
			fpu_addr <= buf_addr_w'(a);
			tile[a] = dram.mem[12'(base + 32'(a / row_bytes) * stride + 32'(a % row_bytes))];
			@(posedge clk);
			@(negedge clk);
			assert (fpu_rdata == tile[a]) else raise_error($sformatf(
				"buffer byte %0d is %h, expected %h", a, fpu_rdata, tile[a]));
		end
	endtask

	task automatic check_dram(input logic [addr_w-1:0] base, input logic [addr_w-1:0] stride);
		logic [11:0] da;
		for (int a = 0; a < buf_bytes; a++) begin
			da = 12'(base + 32'(a / row_bytes) * stride + 32'(a % row_bytes));
			assert (dram.mem[da] == tile[a]) else raise_error($sformatf(
				"dram byte %h is %h, expected %h", da, dram.mem[da], tile[a]));
		end
	endtask

	always @(posedge clk) begin
		if (start && !busy) begin
			row_idx <= '0;
		end else if (req.request) begin
			row_idx <= row_idx + 3'd1;
		end
		if (req.request) begin
			ready_count <= '0; // counted per row
		end else if (req.fpu_ready) begin
			ready_count <= ready_count + 8'd1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("Run timed out: no result after %0d cycles", max_cycles);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	idle_before_start: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !busy && !req.request && !req.fpu_ready)
		else raise_error("engine left idle before any start");
	request_per_row: assert property (@(posedge clk) disable iff (!rst_n)
		req.request |-> req.address == exp_base + 32'(row_idx) * exp_stride
			&& req.request_size == 8'(row_lines) && req.rd_wr == exp_write)
		else raise_error("request address, size or direction does not match the row");
	ready_with_dram: assert property (@(posedge clk) disable iff (!rst_n)
		req.fpu_ready |-> rsp.dram_ready)
		else raise_error("fpu_ready pulsed while dram_ready was low");
	lines_per_row: assert property (@(posedge clk) disable iff (!rst_n)
		req.fpu_ready |-> ready_count < 8'(row_lines))
		else raise_error("more fpu_ready pulses in the row than lines requested");

	initial begin
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (8) @(posedge clk); // idle window
		preload_buffer();
		run_command(1'b1, 32'h040, 32'h100, 1'b0);
		check_dram(32'h040, 32'h100);
		run_command(1'b0, 32'h400, 32'h200, 1'b1);
		check_buffer(32'h400, 32'h200);
		// tile just read goes out again at a new base and stride
		run_command(1'b1, 32'hb00, 32'h140, 1'b1);
		check_dram(32'hb00, 32'h140);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
logic/fpu_dma_pkg.sv
logic/fpu_dma_fsm.sv
logic/fpu_dma_counters.sv
logic/line_packer.sv
logic/line_unpacker.sv
logic/tile_buffer.sv
logic/fpu_dma_top.sv
sim/dram_model.sv
sim/tb_fpu_dma.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_fpu_dma -o tb_fpu_dma

out=$(./obj_dir/tb_fpu_dma 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Result: PASSED"
